//--- rot_top.f
+incdir+source
source/rot_pkg.sv
source/rot_boot_ctrl.sv
source/rot_mailbox.sv
source/rot_reg_ifc.sv
source/rot_top.sv
verification/rot_sram_model.sv
verification/rot_top_checker.sv
verification/rot_top_tb.sv

//--- source/rot_boot_ctrl.sv
// Boot controller and fuse storage
`timescale 1ns/10ps
`default_nettype none

`include "rot_cfg.svh"

module rot_boot_ctrl (
    input  wire                   clk,
    input  wire                   reset,
    input  wire                   boot_brkpoint,
    input  wire                   fuse_wr,
    input  wire rot_pkg::fuse_idx_t fuse_idx,
    input  wire rot_pkg::reg_data_t fuse_wdata,
    input  wire                   fuse_done,
    input  wire rot_pkg::fuse_idx_t fuse_rd_idx,
    output rot_pkg::reg_data_t    fuse_rdata,
    output rot_pkg::boot_state_e  boot_state
);

    import rot_pkg::*;

    boot_state_e state_next;
    reg_data_t   fuse_mem [`ROT_FUSE_WORDS];

    // Boot sequence
    always_comb begin
        state_next = boot_state;
        case (boot_state)
            BOOT_IDLE: begin
                state_next = BOOT_FUSE;
            end
            BOOT_FUSE: begin
                if (fuse_done) begin
                    state_next = boot_brkpoint ? BOOT_BRKPT : BOOT_READY;
                end
            end
            // Held here until the debugger lets go
            BOOT_BRKPT: begin
                if (!boot_brkpoint) begin
                    state_next = BOOT_READY;
                end
            end
            default: begin
                state_next = BOOT_READY;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            boot_state <= BOOT_IDLE;
        end else begin
            boot_state <= state_next;
        end
    end

    // Fuse words are writable only during the fuse window
    always_ff @(posedge clk) begin
        if (fuse_wr && (boot_state == BOOT_FUSE)) begin
            fuse_mem[fuse_idx] <= fuse_wdata;
        end
    end

    // Locked after the fuse window, reads return zero
    assign fuse_rdata = (boot_state == BOOT_FUSE) ? fuse_mem[fuse_rd_idx] : '0;

endmodule

`default_nettype wire

//--- source/rot_cfg.svh
// Root of trust configuration
`ifndef ROT_CFG_SVH
`define ROT_CFG_SVH

`define ROT_FUSE_WORDS        8
`define ROT_MBOX_DEPTH        64
`define ROT_MBOX_AW           6

`define ROT_REG_STATUS        8'h00
`define ROT_REG_ERROR         8'h01
`define ROT_REG_FUSE_DONE     8'h02
`define ROT_REG_FUSE_BASE     8'h10
`define ROT_REG_MBOX_LOCK     8'h20
`define ROT_REG_MBOX_CMD      8'h21
`define ROT_REG_MBOX_DLEN     8'h22
`define ROT_REG_MBOX_DATAIN   8'h23
`define ROT_REG_MBOX_DATAOUT  8'h24
`define ROT_REG_MBOX_EXECUTE  8'h25

`endif

//--- source/rot_mailbox.sv
// SoC mailbox with external SRAM
`timescale 1ns/10ps
`default_nettype none

module rot_mailbox (
    input  wire                   clk,
    input  wire                   reset,
    input  wire                   lock_rd,
    input  wire                   cmd_wr,
    input  wire                   dlen_wr,
    input  wire                   datain_wr,
    input  wire                   dataout_rd,
    input  wire                   execute_wr,
    input  wire rot_pkg::reg_data_t wdata,
    input  wire rot_pkg::reg_data_t mbox_sram_rdata,
    output logic                  lock_status,
    output rot_pkg::reg_data_t    cmd,
    output rot_pkg::reg_data_t    dlen,
    output rot_pkg::reg_data_t    dataout,
    output logic                  dataout_valid,
    output logic                  mailbox_data_avail,
    output logic                  mbox_sram_cs,
    output logic                  mbox_sram_we,
    output rot_pkg::mbox_addr_t   mbox_sram_addr,
    output rot_pkg::reg_data_t    mbox_sram_wdata
);

    import rot_pkg::*;

    logic        lock_q;
    logic        datain_acc;
    mbox_addr_t  wr_ptr;
    mbox_addr_t  rd_ptr;
    logic [31:0] rd_ptr_inc;
    logic        rd_wrap;

    // Payload writes only count while the SoC holds the lock
    assign datain_acc = datain_wr & lock_q;

    // Read pointer wraps at the programmed length
    assign rd_ptr_inc = 32'(rd_ptr) + 32'd1;
    assign rd_wrap    = (rd_ptr_inc >= dlen);

    always_ff @(posedge clk) begin
        if (reset) begin
            lock_q             <= 1'b0;
            mailbox_data_avail <= 1'b0;
            cmd                <= '0;
            dlen               <= '0;
            wr_ptr             <= '0;
            rd_ptr             <= '0;
            dataout_valid      <= 1'b0;
        end else begin
            dataout_valid <= dataout_rd;
            // Reading the lock register grabs the lock
            if (lock_rd) begin
                lock_q <= 1'b1;
            end
            if (cmd_wr && lock_q) begin
                cmd <= wdata;
            end
            if (dlen_wr && lock_q) begin
                dlen <= wdata;
            end
            if (datain_acc) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (dataout_rd) begin
                rd_ptr <= rd_wrap ? '0 : mbox_addr_t'(rd_ptr_inc);
            end
            if (execute_wr && lock_q) begin
                if (wdata[0]) begin
                    mailbox_data_avail <= 1'b1;
                end else begin
                    // Transaction done, hand the mailbox back
                    mailbox_data_avail <= 1'b0;
                    lock_q             <= 1'b0;
                    wr_ptr             <= '0;
                    rd_ptr             <= '0;
                end
            end
        end
    end

    // SRAM port, write and read never coincide
    always_comb begin
        mbox_sram_cs    = datain_acc | dataout_rd;
        mbox_sram_we    = datain_acc;
        mbox_sram_addr  = datain_acc ? wr_ptr : rd_ptr;
        mbox_sram_wdata = wdata;
    end

    assign lock_status = lock_q;
    assign dataout     = mbox_sram_rdata;

endmodule

`default_nettype wire

//--- source/rot_pkg.sv
// Root of trust shared types
`default_nettype none

`include "rot_cfg.svh"

package rot_pkg;

    // Register port
    typedef logic [7:0]  reg_addr_t;
    typedef logic [31:0] reg_data_t;

    // Fuse word index, one per obfuscation word
    typedef logic [2:0]  fuse_idx_t;

    // Mailbox SRAM word address
    typedef logic [`ROT_MBOX_AW-1:0] mbox_addr_t;

    typedef enum logic [1:0] {
        BOOT_IDLE  = 2'b00,
        BOOT_FUSE  = 2'b01,
        BOOT_BRKPT = 2'b10,
        BOOT_READY = 2'b11
    } boot_state_e;

endpackage

`default_nettype wire

//--- source/rot_reg_ifc.sv
// SoC register interface
`timescale 1ns/10ps
`default_nettype none

`include "rot_cfg.svh"

module rot_reg_ifc (
    input  wire                    clk,
    input  wire                    reset,
    input  wire                    reg_wr,
    input  wire                    reg_rd,
    input  wire rot_pkg::reg_addr_t  reg_addr,
    input  wire rot_pkg::reg_data_t  reg_wdata,
    input  wire rot_pkg::boot_state_e boot_state,
    input  wire rot_pkg::reg_data_t  fuse_rdata,
    input  wire                    lock_status,
    input  wire rot_pkg::reg_data_t  cmd,
    input  wire rot_pkg::reg_data_t  dlen,
    input  wire rot_pkg::reg_data_t  dataout,
    input  wire                    dataout_valid,
    input  wire                    mailbox_data_avail,
    output rot_pkg::reg_data_t     reg_rdata,
    output logic                   reg_rd_valid,
    output logic                   error_fatal,
    output logic                   error_non_fatal,
    output logic                   fuse_wr,
    output logic                   fuse_done,
    output rot_pkg::fuse_idx_t     fuse_idx,
    output rot_pkg::fuse_idx_t     fuse_rd_idx,
    output logic                   lock_rd,
    output logic                   cmd_wr,
    output logic                   dlen_wr,
    output logic                   datain_wr,
    output logic                   dataout_rd,
    output logic                   execute_wr
);

    import rot_pkg::*;

    logic      is_fuse;
    logic      is_mbox;
    logic      is_mapped;
    logic      in_fuse;
    logic      in_ready;
    logic      rd_acc;
    logic      rd_pend;
    logic      mbox_wr;
    logic      mbox_rd;
    logic      set_fatal;
    logic      set_non_fatal;
    logic      err_clr;
    reg_data_t rd_mux;

    // Address decode
    assign is_fuse   = (reg_addr >= `ROT_REG_FUSE_BASE) &&
                       (reg_addr < `ROT_REG_FUSE_BASE + `ROT_FUSE_WORDS);
    assign is_mbox   = (reg_addr >= `ROT_REG_MBOX_LOCK) &&
                       (reg_addr <= `ROT_REG_MBOX_EXECUTE);
    assign is_mapped = is_fuse || is_mbox ||
                       (reg_addr inside {`ROT_REG_STATUS, `ROT_REG_ERROR, `ROT_REG_FUSE_DONE});
    assign in_fuse   = (boot_state == BOOT_FUSE);
    assign in_ready  = (boot_state == BOOT_READY);

    // Reads arriving during a data-out fetch are dropped
    assign rd_acc  = reg_rd && !rd_pend;
    assign mbox_wr = reg_wr && in_ready;
    assign mbox_rd = rd_acc && in_ready;

    assign fuse_idx    = fuse_idx_t'(reg_addr - `ROT_REG_FUSE_BASE);
    assign fuse_rd_idx = fuse_idx;
    assign fuse_wr     = reg_wr && is_fuse && in_fuse;
    assign fuse_done   = reg_wr && (reg_addr == `ROT_REG_FUSE_DONE) && in_fuse;

    assign lock_rd    = mbox_rd && (reg_addr == `ROT_REG_MBOX_LOCK);
    assign dataout_rd = mbox_rd && (reg_addr == `ROT_REG_MBOX_DATAOUT);
    assign cmd_wr     = mbox_wr && (reg_addr == `ROT_REG_MBOX_CMD);
    assign dlen_wr    = mbox_wr && (reg_addr == `ROT_REG_MBOX_DLEN);
    assign datain_wr  = mbox_wr && (reg_addr == `ROT_REG_MBOX_DATAIN);
    assign execute_wr = mbox_wr && (reg_addr == `ROT_REG_MBOX_EXECUTE);

    // Access checks
    assign set_fatal     = reg_wr && (is_fuse || (reg_addr == `ROT_REG_FUSE_DONE)) && !in_fuse;
    assign set_non_fatal = (reg_wr || rd_acc) && (!is_mapped || (is_mbox && !in_ready));
    assign err_clr       = reg_wr && (reg_addr == `ROT_REG_ERROR);

    always_ff @(posedge clk) begin
        if (reset) begin
            error_fatal     <= 1'b0;
            error_non_fatal <= 1'b0;
        end else begin
            if (set_fatal) begin
                error_fatal <= 1'b1;
            end else if (err_clr && reg_wdata[0]) begin
                error_fatal <= 1'b0;
            end
            if (set_non_fatal) begin
                error_non_fatal <= 1'b1;
            end else if (err_clr && reg_wdata[1]) begin
                error_non_fatal <= 1'b0;
            end
        end
    end

    always_comb begin
        rd_mux = '0;
        if (is_fuse) begin
            rd_mux = fuse_rdata;
        end else if (is_mbox && !in_ready) begin
            // Blocked mailbox access reads as zero
            rd_mux = '0;
        end else begin
            case (reg_addr)
                `ROT_REG_STATUS:       rd_mux = {29'b0, mailbox_data_avail, in_ready, in_fuse};
                `ROT_REG_ERROR:        rd_mux = {30'b0, error_non_fatal, error_fatal};
                `ROT_REG_FUSE_DONE:    rd_mux = {31'b0, !in_fuse && (boot_state != BOOT_IDLE)};
                `ROT_REG_MBOX_LOCK:    rd_mux = {31'b0, lock_status};
                `ROT_REG_MBOX_CMD:     rd_mux = cmd;
                `ROT_REG_MBOX_DLEN:    rd_mux = dlen;
                `ROT_REG_MBOX_EXECUTE: rd_mux = {31'b0, mailbox_data_avail};
                default:               rd_mux = '0;
            endcase
        end
    end

    // Data-out waits one more cycle for the SRAM
    always_ff @(posedge clk) begin
        if (reset) begin
            reg_rd_valid <= 1'b0;
            rd_pend      <= 1'b0;
        end else begin
            reg_rd_valid <= (rd_acc && !dataout_rd) || (rd_pend && dataout_valid);
            if (dataout_rd) begin
                rd_pend <= 1'b1;
            end else if (dataout_valid) begin
                rd_pend <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rd_acc && !dataout_rd) begin
            reg_rdata <= rd_mux;
        end else if (rd_pend && dataout_valid) begin
            reg_rdata <= dataout;
        end
    end

endmodule

`default_nettype wire

//--- source/rot_top.sv
// Root of trust top level
`timescale 1ns/10ps
`default_nettype none

module rot_top (
    input  wire                   clk,
    input  wire                   reset,
    input  wire                   boot_brkpoint,
    input  wire                   reg_wr,
    input  wire                   reg_rd,
    input  wire rot_pkg::reg_addr_t reg_addr,
    input  wire rot_pkg::reg_data_t reg_wdata,
    output rot_pkg::reg_data_t    reg_rdata,
    output logic                  reg_rd_valid,
    output logic                  mbox_sram_cs,
    output logic                  mbox_sram_we,
    output rot_pkg::mbox_addr_t   mbox_sram_addr,
    output rot_pkg::reg_data_t    mbox_sram_wdata,
    input  wire rot_pkg::reg_data_t mbox_sram_rdata,
    output logic                  ready_for_fuses,
    output logic                  ready_for_mb_processing,
    output logic                  mailbox_data_avail,
    output logic                  error_fatal,
    output logic                  error_non_fatal
);

    import rot_pkg::*;

    boot_state_e boot_state;
    logic        fuse_wr;
    logic        fuse_done;
    fuse_idx_t   fuse_idx;
    fuse_idx_t   fuse_rd_idx;
    reg_data_t   fuse_rdata;
    logic        lock_rd;
    logic        cmd_wr;
    logic        dlen_wr;
    logic        datain_wr;
    logic        dataout_rd;
    logic        execute_wr;
    logic        lock_status;
    reg_data_t   cmd;
    reg_data_t   dlen;
    reg_data_t   dataout;
    logic        dataout_valid;

    assign ready_for_fuses         = (boot_state == BOOT_FUSE);
    assign ready_for_mb_processing = (boot_state == BOOT_READY);

    rot_reg_ifc i_rot_reg_ifc (
        .clk                (clk),
        .reset              (reset),
        .reg_wr             (reg_wr),
        .reg_rd             (reg_rd),
        .reg_addr           (reg_addr),
        .reg_wdata          (reg_wdata),
        .boot_state         (boot_state),
        .fuse_rdata         (fuse_rdata),
        .lock_status        (lock_status),
        .cmd                (cmd),
        .dlen               (dlen),
        .dataout            (dataout),
        .dataout_valid      (dataout_valid),
        .mailbox_data_avail (mailbox_data_avail),
        .reg_rdata          (reg_rdata),
        .reg_rd_valid       (reg_rd_valid),
        .error_fatal        (error_fatal),
        .error_non_fatal    (error_non_fatal),
        .fuse_wr            (fuse_wr),
        .fuse_done          (fuse_done),
        .fuse_idx           (fuse_idx),
        .fuse_rd_idx        (fuse_rd_idx),
        .lock_rd            (lock_rd),
        .cmd_wr             (cmd_wr),
        .dlen_wr            (dlen_wr),
        .datain_wr          (datain_wr),
        .dataout_rd         (dataout_rd),
        .execute_wr         (execute_wr)
    );

    rot_boot_ctrl i_rot_boot_ctrl (
        .clk           (clk),
        .reset         (reset),
        .boot_brkpoint (boot_brkpoint),
        .fuse_wr       (fuse_wr),
        .fuse_idx      (fuse_idx),
        .fuse_wdata    (reg_wdata),
        .fuse_done     (fuse_done),
        .fuse_rd_idx   (fuse_rd_idx),
        .fuse_rdata    (fuse_rdata),
        .boot_state    (boot_state)
    );

    rot_mailbox i_rot_mailbox (
        .clk                (clk),
        .reset              (reset),
        .lock_rd            (lock_rd),
        .cmd_wr             (cmd_wr),
        .dlen_wr            (dlen_wr),
        .datain_wr          (datain_wr),
        .dataout_rd         (dataout_rd),
        .execute_wr         (execute_wr),
        .wdata              (reg_wdata),
        .mbox_sram_rdata    (mbox_sram_rdata),
        .lock_status        (lock_status),
        .cmd                (cmd),
        .dlen               (dlen),
        .dataout            (dataout),
        .dataout_valid      (dataout_valid),
        .mailbox_data_avail (mailbox_data_avail),
        .mbox_sram_cs       (mbox_sram_cs),
        .mbox_sram_we       (mbox_sram_we),
        .mbox_sram_addr     (mbox_sram_addr),
        .mbox_sram_wdata    (mbox_sram_wdata)
    );

endmodule

`default_nettype wire

//--- verification/rot_sram_model.sv
// Mailbox SRAM model
`timescale 1ns/10ps
`default_nettype none

`include "rot_cfg.svh"

module rot_sram_model (
    input  wire                     clk,
    input  wire                     cs,
    input  wire                     we,
    input  wire rot_pkg::mbox_addr_t addr,
    input  wire rot_pkg::reg_data_t  wdata,
    output rot_pkg::reg_data_t       rdata
);

    import rot_pkg::*;

    reg_data_t mem [`ROT_MBOX_DEPTH];

    // Known and distinct contents for every word
    initial begin
        for (int i = 0; i < `ROT_MBOX_DEPTH; i++) begin
            mem[i] = 32'hC0DE_0000 | 32'(i);
        end
        rdata = '0;
    end

    // Read data shows up one cycle after the select and holds
    always @(posedge clk) begin
        if (cs && we) begin
            mem[addr] <= wdata;
        end else if (cs) begin
            rdata <= mem[addr];
        end
    end

endmodule

`default_nettype wire

//--- verification/rot_top_checker.sv
// Root of trust protocol assertions
`timescale 1ns/10ps
`default_nettype none

module rot_top_checker (
    input wire clk,
    input wire reset,
    input wire ready_for_fuses,
    input wire ready_for_mb_processing,
    input wire reg_rd_valid,
    input wire mailbox_data_avail,
    input wire mbox_sram_cs,
    input wire mbox_sram_we
);

    int assert_failures = 0;

    // Boot can't be in fuse window and ready at once
    a_ready_exclusive: assert property (@(posedge clk) disable iff (reset)
        !(ready_for_fuses && ready_for_mb_processing))
    else begin
        assert_failures++;
        $error("ready_for_fuses and ready_for_mb_processing both high");
    end

    a_rd_valid_pulse: assert property (@(posedge clk) disable iff (reset)
        reg_rd_valid |=> !reg_rd_valid)
    else begin
        assert_failures++;
        $error("reg_rd_valid high for two cycles");
    end

    // Mailbox only has data once boot is complete
    a_avail_ready: assert property (@(posedge clk) disable iff (reset)
        mailbox_data_avail |-> ready_for_mb_processing)
    else begin
        assert_failures++;
        $error("mailbox_data_avail high outside BOOT_READY");
    end

    a_we_cs: assert property (@(posedge clk) disable iff (reset)
        mbox_sram_we |-> mbox_sram_cs)
    else begin
        assert_failures++;
        $error("mbox_sram_we high without mbox_sram_cs");
    end

endmodule

`default_nettype wire

//--- verification/rot_top_tb.sv
// Root of trust testbench
`timescale 1ns/10ps
`default_nettype none

`include "rot_cfg.svh"

module rot_top_tb;

    import rot_pkg::*;

    localparam int RD_TIMEOUT = 16;

    logic        clk;
    logic        reset;
    logic        boot_brkpoint;
    logic        reg_wr;
    logic        reg_rd;
    reg_addr_t   reg_addr;
    reg_data_t   reg_wdata;
    reg_data_t   reg_rdata;
    logic        reg_rd_valid;
    logic        mbox_sram_cs;
    logic        mbox_sram_we;
    mbox_addr_t  mbox_sram_addr;
    reg_data_t   mbox_sram_wdata;
    reg_data_t   mbox_sram_rdata;
    logic        ready_for_fuses;
    logic        ready_for_mb_processing;
    logic        mailbox_data_avail;
    logic        error_fatal;
    logic        error_non_fatal;
    logic [31:0] lfsr_state;
    int          check_errors;
    int          other_errors;

    rot_top i_rot_top (
        .clk                     (clk),
        .reset                   (reset),
        .boot_brkpoint           (boot_brkpoint),
        .reg_wr                  (reg_wr),
        .reg_rd                  (reg_rd),
        .reg_addr                (reg_addr),
        .reg_wdata               (reg_wdata),
        .reg_rdata               (reg_rdata),
        .reg_rd_valid            (reg_rd_valid),
        .mbox_sram_cs            (mbox_sram_cs),
        .mbox_sram_we            (mbox_sram_we),
        .mbox_sram_addr          (mbox_sram_addr),
        .mbox_sram_wdata         (mbox_sram_wdata),
        .mbox_sram_rdata         (mbox_sram_rdata),
        .ready_for_fuses         (ready_for_fuses),
        .ready_for_mb_processing (ready_for_mb_processing),
        .mailbox_data_avail      (mailbox_data_avail),
        .error_fatal             (error_fatal),
        .error_non_fatal         (error_non_fatal)
    );

    rot_sram_model i_rot_sram_model (
        .clk   (clk),
        .cs    (mbox_sram_cs),
        .we    (mbox_sram_we),
        .addr  (mbox_sram_addr),
        .wdata (mbox_sram_wdata),
        .rdata (mbox_sram_rdata)
    );

    bind rot_top rot_top_checker i_rot_top_checker (
        .clk                     (clk),
        .reset                   (reset),
        .ready_for_fuses         (ready_for_fuses),
        .ready_for_mb_processing (ready_for_mb_processing),
        .reg_rd_valid            (reg_rd_valid),
        .mailbox_data_avail      (mailbox_data_avail),
        .mbox_sram_cs            (mbox_sram_cs),
        .mbox_sram_we            (mbox_sram_we)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        logic feedback;
        feedback = state[31] ^ state[21] ^ state[1] ^ state[0];
        return {state[30:0], feedback};
    endfunction

    task random_word(output reg_data_t word);
        word = '0;
        for (int i = 0; i < 32; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            word = {word[30:0], lfsr_state[0]};
        end
    endtask

    task finish_run;
        int failures;
        failures = check_errors + other_errors + i_rot_top.i_rot_top_checker.assert_failures;
        $display("Value errors: %0d, other errors: %0d, assertion failures: %0d",
                 check_errors, other_errors, i_rot_top.i_rot_top_checker.assert_failures);
        if (failures == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    endtask

    task check_value(input string name, input reg_data_t got, input reg_data_t exp);
        if (got !== exp) begin
            $display("Error: %s is 0x%h, expected 0x%h", name, got, exp);
            check_errors++;
        end
    endtask

    // Bus tasks start and end 1 ns after a rising edge
    task reg_write(input reg_addr_t addr, input reg_data_t data);
        reg_wr = 1'b1;
        reg_addr = addr;
        reg_wdata = data;
        @(posedge clk);
        #1;
        reg_wr = 1'b0;
    endtask

    task reg_read(input reg_addr_t addr, output reg_data_t data);
        int cycles;
        reg_rd = 1'b1;
        reg_addr = addr;
        @(posedge clk);
        #1;
        reg_rd = 1'b0;
        cycles = 0;
        while (!reg_rd_valid && cycles < RD_TIMEOUT) begin
            @(posedge clk);
            #1;
            cycles++;
        end
        if (!reg_rd_valid) begin
            $display("Read of register 0x%h got no reg_rd_valid in time", addr);
            other_errors++;
            finish_run();
        end else begin
            data = reg_rdata;
            // Let the valid pulse end before the next access
            @(posedge clk);
            #1;
        end
    endtask

    task read_expect(input reg_addr_t addr, input reg_data_t exp);
        reg_data_t data;
        reg_read(addr, data);
        check_value("reg_rdata", data, exp);
    endtask

    task apply_reset;
        reset = 1'b1;
        repeat (5) @(posedge clk);
        #1;
        reset = 1'b0;
    endtask

    task wait_for_fuses;
        int cycles;
        cycles = 0;
        while (!ready_for_fuses && cycles < 10) begin
            @(posedge clk);
            #1;
            cycles++;
        end
        if (!ready_for_fuses) begin
            $display("ready_for_fuses did not rise after reset");
            other_errors++;
            finish_run();
        end
    endtask

    task test_reset_boot;
        apply_reset();
        check_value("ready_for_mb_processing", ready_for_mb_processing, 0);
        check_value("mailbox_data_avail", mailbox_data_avail, 0);
        check_value("error_fatal", error_fatal, 0);
        check_value("error_non_fatal", error_non_fatal, 0);
        wait_for_fuses();
        check_value("ready_for_mb_processing", ready_for_mb_processing, 0);
        read_expect(`ROT_REG_STATUS, 32'h1);
    endtask

    task test_fuses;
        reg_data_t fuse_words [`ROT_FUSE_WORDS];
        for (int i = 0; i < `ROT_FUSE_WORDS; i++) begin
            random_word(fuse_words[i]);
            reg_write(reg_addr_t'(`ROT_REG_FUSE_BASE + i), fuse_words[i]);
        end
        for (int i = 0; i < `ROT_FUSE_WORDS; i++) begin
            read_expect(reg_addr_t'(`ROT_REG_FUSE_BASE + i), fuse_words[i]);
        end
        reg_write(`ROT_REG_FUSE_DONE, 32'h1);
        check_value("ready_for_mb_processing", ready_for_mb_processing, 1);
        check_value("ready_for_fuses", ready_for_fuses, 0);
        // Locked words read as zero
        for (int i = 0; i < `ROT_FUSE_WORDS; i++) begin
            read_expect(reg_addr_t'(`ROT_REG_FUSE_BASE + i), 32'h0);
        end
        check_value("error_fatal", error_fatal, 0);
    endtask

    task test_breakpoint;
        apply_reset();
        wait_for_fuses();
        boot_brkpoint = 1'b1;
        reg_write(`ROT_REG_FUSE_DONE, 32'h1);
        check_value("ready_for_fuses", ready_for_fuses, 0);
        repeat (3) @(posedge clk);
        #1;
        check_value("ready_for_mb_processing", ready_for_mb_processing, 0);
        boot_brkpoint = 1'b0;
        @(posedge clk);
        #1;
        check_value("ready_for_mb_processing", ready_for_mb_processing, 1);
    endtask

    task test_mailbox;
        reg_data_t command;
        reg_data_t payload [5];
        read_expect(`ROT_REG_MBOX_LOCK, 32'h0);
        read_expect(`ROT_REG_MBOX_LOCK, 32'h1);
        random_word(command);
        reg_write(`ROT_REG_MBOX_CMD, command);
        reg_write(`ROT_REG_MBOX_DLEN, 32'd5);
        for (int i = 0; i < 5; i++) begin
            random_word(payload[i]);
            reg_write(`ROT_REG_MBOX_DATAIN, payload[i]);
        end
        reg_write(`ROT_REG_MBOX_EXECUTE, 32'h1);
        check_value("mailbox_data_avail", mailbox_data_avail, 1);
        read_expect(`ROT_REG_STATUS, 32'h6);
        read_expect(`ROT_REG_MBOX_CMD, command);
        for (int i = 0; i < 5; i++) begin
            read_expect(`ROT_REG_MBOX_DATAOUT, payload[i]);
        end
        reg_write(`ROT_REG_MBOX_EXECUTE, 32'h0);
        check_value("mailbox_data_avail", mailbox_data_avail, 0);
        read_expect(`ROT_REG_MBOX_LOCK, 32'h0);
    endtask

    task test_errors;
        reg_data_t data;
        apply_reset();
        wait_for_fuses();
        // Mailbox is closed until boot completes
        reg_write(`ROT_REG_MBOX_CMD, 32'h1234);
        check_value("error_non_fatal", error_non_fatal, 1);
        check_value("error_fatal", error_fatal, 0);
        read_expect(`ROT_REG_ERROR, 32'h2);
        reg_write(`ROT_REG_ERROR, 32'h2);
        check_value("error_non_fatal", error_non_fatal, 0);
        reg_write(`ROT_REG_FUSE_DONE, 32'h1);
        reg_write(`ROT_REG_FUSE_BASE, 32'hFFFF_FFFF);
        check_value("error_fatal", error_fatal, 1);
        check_value("error_non_fatal", error_non_fatal, 0);
        reg_read(8'h3F, data);
        check_value("error_non_fatal", error_non_fatal, 1);
        read_expect(`ROT_REG_ERROR, 32'h3);
        reg_write(`ROT_REG_ERROR, 32'h3);
        check_value("error_fatal", error_fatal, 0);
        check_value("error_non_fatal", error_non_fatal, 0);
    endtask

    initial begin
        reset = 1'b1;
        boot_brkpoint = 1'b0;
        reg_wr = 1'b0;
        reg_rd = 1'b0;
        reg_addr = '0;
        reg_wdata = '0;
        lfsr_state = 32'd98874;
        check_errors = 0;
        other_errors = 0;
        test_reset_boot();
        test_fuses();
        test_breakpoint();
        test_mailbox();
        test_errors();
        finish_run();
    end

endmodule

`default_nettype wire
